// File: rv_mem_subsys.f
verilog/mem_subsys_pkg.sv
verilog/byte_sequencer.sv
verilog/mem_ctrl.sv
verilog/icache.sv
verilog/mem_subsys.sv
verification/tb_mem_subsys.sv

// File: Makefile
# Verilator build and run for the memory subsystem testbench

TOP := tb_mem_subsys

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f rv_mem_subsys.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

// File: verification/tb_mem_subsys.sv
// ----------------------------------------------------------------------
// testbench for mem_subsys with byte bus memory model and reference model
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module tb_mem_subsys;

  localparam int MEM_BYTES  = mem_subsys_pkg::MEM_BYTES;
  // fetch pairs, loads, store/load pairs, I/O and arbitration, flush, random
  localparam int N_OPS      = 8 * 2 + 40 + 40 + 4 + 3 + 60;
  localparam int MAX_CYCLES = 40 * N_OPS;

  logic                               clk_in;
  logic                               reset;
  logic                               rdy_in;
  logic                               flush;
  logic                               fetch;
  logic [31:0]                        fetch_pc;
  logic                               instr_valid;
  logic [31:0]                        instr;
  logic                               ls_read;
  logic                               ls_write;
  logic [31:0]                        ls_addr;
  mem_subsys_pkg::mem_len_t           ls_len;
  logic [31:0]                        ls_wdata;
  logic                               ls_done;
  logic [31:0]                        ls_rdata;
  logic [7:0]                         mem_din;
  logic [7:0]                         mem_dout;
  logic [31:0]                        mem_a;
  logic                               mem_wr;
  logic                               io_buffer_full;

  // bus side memory and the reference copy kept by the testbench
  logic [7:0]   ram [MEM_BYTES];
  logic [7:0]   ref_ram [MEM_BYTES];
  logic [31:0]  exp_wa [$];
  logic [7:0]   exp_wd [$];
  logic [7:0]   io_q [$];

  logic [15:0]  lfsr_q;
  logic         rdy_rand;
  logic [31:0]  snap_a;
  logic         snap_wr;
  logic         snap_rdy;
  logic         snap_valid;
  int           cycles;

  mem_subsys #(
    .ICACHE_INDEX_BITS (6)
  ) dut0 (
    .clk_in         (clk_in),
    .reset          (reset),
    .rdy_in         (rdy_in),
    .flush          (flush),
    .fetch          (fetch),
    .fetch_pc       (fetch_pc),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .ls_read        (ls_read),
    .ls_write       (ls_write),
    .ls_addr        (ls_addr),
    .ls_len         (ls_len),
    .ls_wdata       (ls_wdata),
    .ls_done        (ls_done),
    .ls_rdata       (ls_rdata),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full)
  );

  initial begin
    clk_in = 1'b0;
    forever #4 clk_in = ~clk_in;
  end

  // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s at %0t", msg, $time);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  function automatic int len_bytes(input mem_subsys_pkg::mem_len_t l);
    case (l)
      mem_subsys_pkg::LEN_BYTE: return 1;
      mem_subsys_pkg::LEN_HALF: return 2;
      default:                  return 4;
    endcase
  endfunction

  // little-endian zero-extended value from the reference copy
  function automatic logic [31:0] expect_read(input logic [31:0] a, input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[8*k +: 8] = ref_ram[int'(a[16:0]) + k];
    end
    return v;
  endfunction

  // bus memory with one read cycle of latency counted in rdy_in cycles
  always @(posedge clk_in) begin
    if (rdy_in) begin
      mem_din <= ram[mem_a[16:0]];
    end
    if (!reset && rdy_in && mem_wr) begin
      if (exp_wa.size() == 0) begin
        stop_run("bus write with no store outstanding");
      end
      compare_value("mem_a", mem_a, exp_wa.pop_front());
      compare_value("mem_dout", {24'b0, mem_dout}, {24'b0, exp_wd.pop_front()});
      if (mem_a[17:16] == mem_subsys_pkg::IO_SEL) begin
        if (io_buffer_full) begin
          stop_run("I/O write on the bus while io_buffer_full is high");
        end
        io_q.push_back(mem_dout);
      end else begin
        ram[mem_a[16:0]] <= mem_dout;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_run("run did not finish within the cycle limit");
    end
  end

  // one clock with inputs driven on the falling edge and outputs read once settled
  task automatic step_cycle(input logic f, input logic rd, input logic wr,
                            input logic fl);
    @(negedge clk_in);
    if (snap_valid && !snap_rdy) begin
      compare_value("mem_a", mem_a, snap_a);
      compare_value("mem_wr", mem_wr, snap_wr);
    end
    fetch    = f;
    ls_read  = rd;
    ls_write = wr;
    flush    = fl;
    if (f || rd || wr || fl || !rdy_rand) begin
      rdy_in = 1'b1;
    end else begin
      rdy_in = (rand_bits(2) != 0);
    end
    #1;
    snap_a     = mem_a;
    snap_wr    = mem_wr;
    snap_rdy   = rdy_in;
    snap_valid = 1'b1;
    if (!rdy_in) begin
      compare_value("ls_done", ls_done, 0);
      compare_value("instr_valid", instr_valid, 0);
    end
  endtask

  task automatic fetch_instr(input logic [31:0] pc, output int lat);
    fetch_pc = pc;
    step_cycle(1, 0, 0, 0);
    lat = 0;
    do begin
      step_cycle(0, 0, 0, 0);
      lat++;
    end while (!instr_valid);
    compare_value("instr", instr, expect_read({pc[31:2], 2'b00}, 4));
  endtask

  task automatic load_check(input logic [31:0] a, input mem_subsys_pkg::mem_len_t l);
    ls_addr = a;
    ls_len  = l;
    step_cycle(0, 1, 0, 0);
    do step_cycle(0, 0, 0, 0); while (!ls_done);
    compare_value("ls_rdata", ls_rdata, expect_read(a, len_bytes(l)));
  endtask

  task automatic store_data(input logic [31:0] a, input mem_subsys_pkg::mem_len_t l,
                            input logic [31:0] d);
    ls_addr  = a;
    ls_len   = l;
    ls_wdata = d;
    for (int k = 0; k < len_bytes(l); k++) begin
      exp_wa.push_back(a + k);
      exp_wd.push_back(d[8*k +: 8]);
      if (a[17:16] != mem_subsys_pkg::IO_SEL) begin
        ref_ram[int'(a[16:0]) + k] = d[8*k +: 8];
      end
    end
    step_cycle(0, 0, 1, 0);
    do step_cycle(0, 0, 0, 0); while (!ls_done);
  endtask

  function automatic mem_subsys_pkg::mem_len_t rand_len();
    case (rand_bits(2))
      0:       return mem_subsys_pkg::LEN_BYTE;
      1:       return mem_subsys_pkg::LEN_HALF;
      default: return mem_subsys_pkg::LEN_WORD;
    endcase
  endfunction

  // naturally aligned data address in 0x10000..0x17fff
  function automatic logic [31:0] rand_data_addr(input mem_subsys_pkg::mem_len_t l);
    logic [31:0] a;
    a = 32'h10000 | rand_bits(15);
    if (l == mem_subsys_pkg::LEN_HALF) a[0] = 1'b0;
    if (l == mem_subsys_pkg::LEN_WORD) a[1:0] = 2'b00;
    return a;
  endfunction

  initial begin
    logic [31:0]               pc;
    logic [31:0]               a;
    logic [31:0]               d;
    mem_subsys_pkg::mem_len_t  l;
    int                        lat;
    logic                      got_ls;
    logic                      got_iv;

    lfsr_q = 16'd60;
    cycles = 0;
    reset = 1'b1;
    rdy_in = 1'b1;
    flush = 1'b0;
    fetch = 1'b0;
    fetch_pc = '0;
    ls_read = 1'b0;
    ls_write = 1'b0;
    ls_addr = '0;
    ls_len = mem_subsys_pkg::LEN_WORD;
    ls_wdata = '0;
    mem_din = '0;
    io_buffer_full = 1'b0;
    rdy_rand = 1'b0;
    snap_valid = 1'b0;
    snap_rdy = 1'b1;
    for (int i = 0; i < MEM_BYTES; i++) begin
      ram[i] = rand_bits(8) ^ i[7:0] ^ i[15:8] ^ {7'b0, i[16]};
      ref_ram[i] = ram[i];
    end
    repeat (10) @(posedge clk_in);
    @(negedge clk_in);
    reset = 1'b0;

    // miss then hit with code kept below 0x800
    for (int i = 0; i < 8; i++) begin
      pc = {21'b0, rand_bits(9), 2'b00};
      fetch_instr(pc, lat);
      a = mem_a;
      fetch_instr(pc, lat);
      compare_value("hit latency", lat, 1);
      // a refill started by the hit would have moved the bus address by now
      repeat (2) step_cycle(0, 0, 0, 0);
      compare_value("mem_a", mem_a, a);
    end

    for (int i = 0; i < 40; i++) begin
      l = rand_len();
      load_check(rand_data_addr(l), l);
    end

    for (int i = 0; i < 20; i++) begin
      l = rand_len();
      a = rand_data_addr(l);
      store_data(a, l, rand_bits(32));
      load_check(a, l);
    end

    // held I/O store
    io_buffer_full = 1'b1;
    d = rand_bits(32);
    ls_addr = 32'h30000;
    ls_len = mem_subsys_pkg::LEN_WORD;
    ls_wdata = d;
    for (int k = 0; k < 4; k++) begin
      exp_wa.push_back(32'h30000 + k);
      exp_wd.push_back(d[8*k +: 8]);
    end
    step_cycle(0, 0, 1, 0);
    repeat (20) begin
      step_cycle(0, 0, 0, 0);
      if (ls_done) stop_run("I/O store finished while io_buffer_full was high");
    end
    io_buffer_full = 1'b0;
    do step_cycle(0, 0, 0, 0); while (!ls_done);
    // last byte is taken by the bus at the edge after done
    step_cycle(0, 0, 0, 0);
    compare_value("io bytes", io_q.size(), 4);
    for (int k = 0; k < 4; k++) begin
      compare_value("io byte", {24'b0, io_q.pop_front()}, {24'b0, d[8*k +: 8]});
    end

    // load wins over a fetch miss issued in the same cycle
    fetch_pc = 32'h0ffc;
    ls_addr = 32'h10100;
    ls_len = mem_subsys_pkg::LEN_WORD;
    step_cycle(1, 1, 0, 0);
    step_cycle(0, 0, 0, 0);
    step_cycle(0, 0, 0, 0);
    compare_value("mem_a", mem_a, 32'h10100);
    got_ls = 1'b0;
    got_iv = 1'b0;
    while (!(got_ls && got_iv)) begin
      if (ls_done) begin
        compare_value("ls_rdata", ls_rdata, expect_read(32'h10100, 4));
        got_ls = 1'b1;
      end
      if (instr_valid) begin
        compare_value("instr", instr, expect_read(32'h0ffc, 4));
        got_iv = 1'b1;
      end
      if (!(got_ls && got_iv)) step_cycle(0, 0, 0, 0);
    end

    // flush during a miss
    fetch_pc = 32'h0ff8;
    step_cycle(1, 0, 0, 0);
    step_cycle(0, 0, 0, 1);
    repeat (15) begin
      step_cycle(0, 0, 0, 0);
      if (instr_valid) stop_run("instr_valid for a fetch that was flushed");
    end
    fetch_instr(32'h0ff8, lat);
    compare_value("hit latency", lat, 1);

    // mixed traffic with rdy_in dropping at random
    rdy_rand = 1'b1;
    for (int i = 0; i < 60; i++) begin
      case (rand_bits(2))
        0: fetch_instr({21'b0, rand_bits(9), 2'b00}, lat);
        1: begin
          l = rand_len();
          load_check(rand_data_addr(l), l);
        end
        default: begin
          l = rand_len();
          store_data(rand_data_addr(l), l, rand_bits(32));
        end
      endcase
    end
    rdy_rand = 1'b0;
    step_cycle(0, 0, 0, 0);

    compare_value("pending bus writes", exp_wa.size(), 0);
    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: verilog/mem_subsys.sv
// ----------------------------------------------------------------------
// memory side top level: instruction cache, controller, byte sequencer
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mem_subsys #(
  parameter int ICACHE_INDEX_BITS = 6
) (
  input  logic                                clk_in,
  input  logic                                reset,
  input  logic                                rdy_in,
  input  logic                                flush,
  // fetch port
  input  logic                                fetch,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   fetch_pc,
  output logic                                instr_valid,
  output logic [mem_subsys_pkg::DATA_W-1:0]   instr,
  // load/store port
  input  logic                                ls_read,
  input  logic                                ls_write,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   ls_addr,
  input  mem_subsys_pkg::mem_len_t            ls_len,
  input  logic [mem_subsys_pkg::DATA_W-1:0]   ls_wdata,
  output logic                                ls_done,
  output logic [mem_subsys_pkg::DATA_W-1:0]   ls_rdata,
  // external byte bus
  input  logic [mem_subsys_pkg::BYTE_W-1:0]   mem_din,
  output logic [mem_subsys_pkg::BYTE_W-1:0]   mem_dout,
  output logic [mem_subsys_pkg::ADDR_W-1:0]   mem_a,
  output logic                                mem_wr,
  input  logic                                io_buffer_full
);

  // cache to controller
  logic                               ic_req;
  logic [mem_subsys_pkg::ADDR_W-1:0]  ic_addr;
  logic                               ic_done;
  logic [mem_subsys_pkg::DATA_W-1:0]  ic_word;

  // controller to sequencer
  logic                               seq_start;
  logic [mem_subsys_pkg::ADDR_W-1:0]  seq_addr;
  mem_subsys_pkg::mem_len_t           seq_len;
  logic                               seq_write;
  logic [mem_subsys_pkg::DATA_W-1:0]  seq_wdata;
  logic                               seq_busy;
  logic                               seq_done;
  logic [mem_subsys_pkg::DATA_W-1:0]  seq_rdata;

  icache #(
    .ICACHE_INDEX_BITS (ICACHE_INDEX_BITS)
  ) icache0 (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .flush       (flush),
    .fetch       (fetch),
    .fetch_pc    (fetch_pc),
    .ic_done     (ic_done),
    .ic_word     (ic_word),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ic_req      (ic_req),
    .ic_addr     (ic_addr)
  );

  mem_ctrl mem_ctrl0 (
    .clk_in         (clk_in),
    .reset          (reset),
    .rdy_in         (rdy_in),
    .ic_req         (ic_req),
    .ic_addr        (ic_addr),
    .ls_read        (ls_read),
    .ls_write       (ls_write),
    .ls_addr        (ls_addr),
    .ls_len         (ls_len),
    .ls_wdata       (ls_wdata),
    .io_buffer_full (io_buffer_full),
    .seq_busy       (seq_busy),
    .seq_done       (seq_done),
    .seq_rdata      (seq_rdata),
    .ic_done        (ic_done),
    .ic_word        (ic_word),
    .ls_done        (ls_done),
    .ls_rdata       (ls_rdata),
    .seq_start      (seq_start),
    .seq_addr       (seq_addr),
    .seq_len        (seq_len),
    .seq_write      (seq_write),
    .seq_wdata      (seq_wdata)
  );

  byte_sequencer byte_sequencer0 (
    .clk_in    (clk_in),
    .reset     (reset),
    .rdy_in    (rdy_in),
    .seq_start (seq_start),
    .seq_addr  (seq_addr),
    .seq_len   (seq_len),
    .seq_write (seq_write),
    .seq_wdata (seq_wdata),
    .mem_din   (mem_din),
    .seq_busy  (seq_busy),
    .seq_done  (seq_done),
    .seq_rdata (seq_rdata),
    .mem_a     (mem_a),
    .mem_dout  (mem_dout),
    .mem_wr    (mem_wr)
  );

endmodule

// File: verilog/icache.sv
// ----------------------------------------------------------------------
// direct-mapped instruction cache, one word per line, filled through
// the memory controller on a miss
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module icache #(
  parameter int ICACHE_INDEX_BITS = 6
) (
  input  logic                                clk_in,
  input  logic                                reset,
  input  logic                                rdy_in,
  input  logic                                flush,
  input  logic                                fetch,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   fetch_pc,
  input  logic                                ic_done,
  input  logic [mem_subsys_pkg::DATA_W-1:0]   ic_word,
  output logic                                instr_valid,
  output logic [mem_subsys_pkg::DATA_W-1:0]   instr,
  output logic                                ic_req,
  output logic [mem_subsys_pkg::ADDR_W-1:0]   ic_addr
);

  localparam int LINES  = 1 << ICACHE_INDEX_BITS;
  localparam int IDX_HI = ICACHE_INDEX_BITS + 1;
  localparam int TAG_LO = ICACHE_INDEX_BITS + 2;
  // tag covers the rest of the 18-bit physical address
  localparam int TAG_W  = 18 - TAG_LO;

  logic [LINES-1:0]                   valid_q;
  logic [TAG_W-1:0]                   tag_q  [LINES];
  logic [mem_subsys_pkg::DATA_W-1:0]  data_q [LINES];

  logic                               instr_valid_q;
  logic [mem_subsys_pkg::DATA_W-1:0]  instr_q;
  logic                               ic_req_q;
  logic [mem_subsys_pkg::ADDR_W-1:0]  ic_addr_q;
  // a flush landed while the fill was running
  logic                               drop_q;
  // fetch that arrived after a flush while the old fill was busy
  logic                               pend_q;
  logic [mem_subsys_pkg::ADDR_W-1:0]  pend_pc_q;

  logic                               look_req;
  logic [mem_subsys_pkg::ADDR_W-1:0]  look_pc;
  logic [ICACHE_INDEX_BITS-1:0]       look_idx;
  logic                               hit;
  logic [ICACHE_INDEX_BITS-1:0]       fill_idx;

  // a flush with no new fetch kills a waiting replay
  assign look_req = !ic_req_q && (fetch || (pend_q && !flush));
  assign look_pc  = pend_q ? pend_pc_q : fetch_pc;
  assign look_idx = look_pc[IDX_HI:2];
  assign hit      = valid_q[look_idx] && (tag_q[look_idx] == look_pc[17:TAG_LO]);
  assign fill_idx = ic_addr_q[IDX_HI:2];

  assign instr_valid = instr_valid_q && rdy_in;
  assign instr       = instr_q;
  assign ic_req      = ic_req_q;
  assign ic_addr     = ic_addr_q;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      valid_q       <= '0;
      instr_valid_q <= 1'b0;
      ic_req_q      <= 1'b0;
      drop_q        <= 1'b0;
      pend_q        <= 1'b0;
    end else if (rdy_in) begin
      instr_valid_q <= 1'b0;
      if (look_req) begin
        pend_q <= 1'b0;
        if (hit) begin
          instr_valid_q <= 1'b1;
          instr_q       <= data_q[look_idx];
        end else begin
          // miss, fetch the aligned word
          ic_req_q  <= 1'b1;
          ic_addr_q <= {look_pc[mem_subsys_pkg::ADDR_W-1:2], 2'b00};
          drop_q    <= 1'b0;
        end
      end else if (ic_req_q) begin
        if (fetch) begin
          pend_q    <= 1'b1;
          pend_pc_q <= fetch_pc;
        end else if (flush) begin
          pend_q <= 1'b0;
        end
        if (flush) begin
          drop_q <= 1'b1;
        end
        if (ic_done) begin
          // line is kept even when the answer is dropped
          ic_req_q           <= 1'b0;
          valid_q[fill_idx]  <= 1'b1;
          tag_q[fill_idx]    <= ic_addr_q[17:TAG_LO];
          data_q[fill_idx]   <= ic_word;
          instr_valid_q      <= !(drop_q || flush);
          instr_q            <= ic_word;
        end
      end else if (flush) begin
        pend_q <= 1'b0;
      end
    end
  end

  // fills only answer an outstanding cache request
  assert property (@(posedge clk_in) disable iff (reset)
    ic_done |-> ic_req_q);

endmodule

// File: verilog/mem_ctrl.sv
// ----------------------------------------------------------------------
// memory controller with load/store latch, arbitration against the cache
// I/O write hold and routing of completions to the owner
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module mem_ctrl (
  input  logic                                clk_in,
  input  logic                                reset,
  input  logic                                rdy_in,
  input  logic                                ic_req,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   ic_addr,
  input  logic                                ls_read,
  input  logic                                ls_write,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   ls_addr,
  input  mem_subsys_pkg::mem_len_t            ls_len,
  input  logic [mem_subsys_pkg::DATA_W-1:0]   ls_wdata,
  input  logic                                io_buffer_full,
  input  logic                                seq_busy,
  input  logic                                seq_done,
  input  logic [mem_subsys_pkg::DATA_W-1:0]   seq_rdata,
  output logic                                ic_done,
  output logic [mem_subsys_pkg::DATA_W-1:0]   ic_word,
  output logic                                ls_done,
  output logic [mem_subsys_pkg::DATA_W-1:0]   ls_rdata,
  output logic                                seq_start,
  output logic [mem_subsys_pkg::ADDR_W-1:0]   seq_addr,
  output mem_subsys_pkg::mem_len_t            seq_len,
  output logic                                seq_write,
  output logic [mem_subsys_pkg::DATA_W-1:0]   seq_wdata
);

  // latched load/store request
  logic                               ls_pend_q;
  logic                               ls_wr_q;
  logic [mem_subsys_pkg::ADDR_W-1:0]  ls_addr_q;
  mem_subsys_pkg::mem_len_t           ls_len_q;
  logic [mem_subsys_pkg::DATA_W-1:0]  ls_wdata_q;
  // owner of the transfer in flight (1 for load/store)
  logic                               own_ls_q;
  logic                               ls_io;
  logic                               ls_hold;
  logic                               start_ls;
  logic                               start_ic;

  assign ls_io   = (ls_addr_q[17:16] == mem_subsys_pkg::IO_SEL);
  // uart cannot take another byte yet
  assign ls_hold = ls_wr_q && ls_io && io_buffer_full;

  // load/store has priority but the cache may go while an I/O write is held
  assign start_ls = rdy_in && !seq_busy && ls_pend_q && !ls_hold;
  assign start_ic = rdy_in && !seq_busy && ic_req && !start_ls;

  assign seq_start = start_ls || start_ic;
  assign seq_addr  = start_ls ? ls_addr_q : ic_addr;
  assign seq_len   = start_ls ? ls_len_q : mem_subsys_pkg::LEN_WORD;
  assign seq_write = start_ls && ls_wr_q;
  assign seq_wdata = ls_wdata_q;

  // completion goes to whoever started the transfer
  assign ls_done  = seq_done && own_ls_q;
  assign ic_done  = seq_done && !own_ls_q;
  assign ls_rdata = seq_rdata;
  assign ic_word  = seq_rdata;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      ls_pend_q <= 1'b0;
      own_ls_q  <= 1'b0;
    end else if (rdy_in) begin
      if (ls_read || ls_write) begin
        ls_pend_q  <= 1'b1;
        ls_wr_q    <= ls_write;
        ls_addr_q  <= ls_addr;
        ls_len_q   <= ls_len;
        ls_wdata_q <= ls_wdata;
      end else if (start_ls) begin
        ls_pend_q <= 1'b0;
      end
      if (seq_start) begin
        own_ls_q <= start_ls;
      end
    end
  end

  // RAM accesses must fall inside the 128 KB array
  assert property (@(posedge clk_in) disable iff (reset)
    (seq_start && seq_addr[17:16] != mem_subsys_pkg::IO_SEL)
      |-> (seq_addr < mem_subsys_pkg::MEM_BYTES));

endmodule

// File: verilog/byte_sequencer.sv
// ----------------------------------------------------------------------
// byte sequencer for the byte-wide external memory bus
// ----------------------------------------------------------------------

`timescale 1ns/100ps

module byte_sequencer (
  input  logic                                clk_in,
  input  logic                                reset,
  input  logic                                rdy_in,
  input  logic                                seq_start,
  input  logic [mem_subsys_pkg::ADDR_W-1:0]   seq_addr,
  input  mem_subsys_pkg::mem_len_t            seq_len,
  input  logic                                seq_write,
  input  logic [mem_subsys_pkg::DATA_W-1:0]   seq_wdata,
  input  logic [mem_subsys_pkg::BYTE_W-1:0]   mem_din,
  output logic                                seq_busy,
  output logic                                seq_done,
  output logic [mem_subsys_pkg::DATA_W-1:0]   seq_rdata,
  output logic [mem_subsys_pkg::ADDR_W-1:0]   mem_a,
  output logic [mem_subsys_pkg::BYTE_W-1:0]   mem_dout,
  output logic                                mem_wr
);

  localparam int BW = mem_subsys_pkg::BYTE_W;

  logic                               busy_q;
  // cycle number since start, byte step_q-1 is on the bus
  logic [2:0]                         step_q;
  logic [2:0]                         nbytes_q;
  logic                               write_q;
  logic [mem_subsys_pkg::DATA_W-1:0]  wdata_q;
  logic [mem_subsys_pkg::DATA_W-1:0]  rdata_q;
  logic [2:0]                         start_bytes;
  logic [2:0]                         rd_idx;
  logic [2:0]                         last_idx;

  // byte count of the requested length
  always_comb begin
    case (seq_len)
      mem_subsys_pkg::LEN_BYTE: start_bytes = 3'd1;
      mem_subsys_pkg::LEN_HALF: start_bytes = 3'd2;
      default:                  start_bytes = 3'd4;
    endcase
  end

  // mem_din in cycle k holds the byte addressed in cycle k-1
  assign rd_idx   = step_q - 3'd2;
  assign last_idx = nbytes_q - 3'd1;

  assign seq_busy = busy_q;

  // writes end with the last byte on the bus, reads one cycle later
  assign seq_done = rdy_in && busy_q &&
                    (write_q ? (step_q == nbytes_q) : (step_q == nbytes_q + 3'd1));

  // last byte comes straight off the bus in the done cycle
  always_comb begin
    seq_rdata = rdata_q;
    seq_rdata[last_idx[1:0]*BW +: BW] = mem_din;
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy_q <= 1'b0;
      step_q <= 3'd0;
      mem_a  <= '0;
      mem_wr <= 1'b0;
    end else if (rdy_in) begin
      if (seq_start) begin
        busy_q   <= 1'b1;
        step_q   <= 3'd1;
        nbytes_q <= start_bytes;
        write_q  <= seq_write;
        mem_a    <= seq_addr;
        mem_wr   <= seq_write;
        mem_dout <= seq_wdata[BW-1:0];
        wdata_q  <= seq_wdata >> BW;
        // cleared so short reads come out zero-extended
        rdata_q  <= '0;
      end else if (busy_q) begin
        if (seq_done) begin
          busy_q <= 1'b0;
          step_q <= 3'd0;
          mem_wr <= 1'b0;
        end else begin
          step_q <= step_q + 3'd1;
          if (step_q < nbytes_q) begin
            // present the next byte
            mem_a    <= mem_a + 1'b1;
            mem_dout <= wdata_q[BW-1:0];
            wdata_q  <= wdata_q >> BW;
          end else begin
            // read tail, bus idle while the last byte returns
            mem_wr <= 1'b0;
          end
          if (!write_q && step_q >= 3'd2) begin
            rdata_q[rd_idx[1:0]*BW +: BW] <= mem_din;
          end
        end
      end
    end
  end

  // the controller only starts a transfer on an idle sequencer
  assert property (@(posedge clk_in) disable iff (reset)
    (rdy_in && seq_start) |-> !seq_busy);

endmodule

// File: verilog/mem_subsys_pkg.sv
// ----------------------------------------------------------------------
// shared widths, memory map constants and the access length type
// for the instruction cache and memory controller
// ----------------------------------------------------------------------

package mem_subsys_pkg;

  // bus and word widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BYTE_W = 8;

  // access length of a load/store or of a sequencer transfer
  typedef enum logic [1:0] {
    LEN_BYTE = 2'd0,
    LEN_HALF = 2'd1,
    LEN_WORD = 2'd2
  } mem_len_t;

  // memory map
  // addr[17:16] == IO_SEL selects I/O space
  localparam logic [1:0] IO_SEL = 2'b11;

  // 128 KB of RAM starting at address 0
  localparam int unsigned MEM_BYTES = 131072;

endpackage
